// File: src/frisc_pkg.sv
`default_nettype none

package frisc_pkg;

	localparam int xlen = 32;          // Data and address width.
	localparam int reg_addr_width = 5; // Register index width.

	// ----------------------------------------
	// Control and datapath encodings
	// ----------------------------------------

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		HALTED
	} seq_state_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_B  // Used by LUI.
	} alu_op_t;

	typedef enum logic [2:0] {
		ALU,
		LOAD,
		STORE,
		BRANCH,
		JAL,
		JALR,
		HALT
	} instr_class_t;

	typedef enum logic [2:0] {
		EQ,
		NE,
		LT,
		GE,
		LTU,
		GEU
	} branch_cond_t;

	typedef enum logic [1:0] {
		BYTE,
		HALF,
		WORD
	} mem_size_t;

endpackage

`default_nettype wire

// File: src/frisc_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_fetch import frisc_pkg::*; #(
	parameter logic [xlen-1:0] RESET_PC = '0
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             fetch_req,
	input  logic             pc_load,
	input  logic             iready,
	input  logic [xlen-1:0]  idata,
	input  instr_class_t     instr_class,
	input  logic             branch_taken,
	input  logic [xlen-1:0]  alu_result,
	output logic [xlen-1:0]  iaddr,
	output logic             ivalid,
	output logic             fetch_done,
	output logic [xlen-1:0]  pc,
	output logic [xlen-1:0]  instr
);

	logic [xlen-1:0] pc_next;

	assign iaddr = pc;                  // PC only moves in writeback.
	assign fetch_done = ivalid & iready; // Handshake cycle.

	// Next-PC selection.
	always_comb begin
		pc_next = pc + 32'd4;
		case (instr_class)
			JALR:    pc_next = {alu_result[xlen-1:1], 1'b0};
			JAL:     pc_next = alu_result;
			BRANCH: begin
				if (branch_taken) begin
					pc_next = alu_result;
				end
			end
			default: pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= RESET_PC;
			ivalid <= 1'b0;
		end else begin
			if (fetch_done) begin
				ivalid <= 1'b0;                 // Drop after the transfer.
			end else if (fetch_req && !ivalid) begin
				ivalid <= 1'b1;                 // One cycle after FETCH entry.
			end
			if (pc_load) begin
				pc <= pc_next;
			end
		end
	end

	// Instruction word is held until the next fetch completes.
	always_ff @(posedge clock) begin
		if (fetch_done) begin
			instr <= idata;
		end
	end

endmodule

`default_nettype wire

// File: src/frisc_decode.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_decode import frisc_pkg::*; (
	input  logic [xlen-1:0]           instr,
	output instr_class_t              instr_class,
	output alu_op_t                   alu_op,
	output branch_cond_t              branch_cond,
	output mem_size_t                 mem_size,
	output logic                      mem_signed,
	output logic [reg_addr_width-1:0] rs1,
	output logic [reg_addr_width-1:0] rs2,
	output logic [reg_addr_width-1:0] rd,
	output logic [xlen-1:0]           imm,
	output logic                      a_sel_pc,
	output logic                      b_sel_imm
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic            funct7_ok;

	// Maps funct3 and the alternate bit onto an ALU operation.
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt ? SUB : ADD;
			3'b001:  op = SLL;
			3'b010:  op = SLT;
			3'b011:  op = SLTU;
			3'b100:  op = XOR;
			3'b101:  op = alt ? SRA : SRL;
			3'b110:  op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Only SUB and SRA/SRAI may use the alternate funct7.
	assign funct7_ok = (funct7 == 7'b0000000) ||
		(funct7 == 7'b0100000 && (funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OPC_OP)));

	always_comb begin
		instr_class = HALT;  // Anything not matched below stops the core.
		alu_op = ADD;
		branch_cond = EQ;
		mem_size = WORD;
		mem_signed = 1'b0;
		imm = imm_i;
		a_sel_pc = 1'b0;
		b_sel_imm = 1'b1;
		case (opcode)
			OPC_LUI: begin
				instr_class = ALU;
				alu_op = PASS_B;
				imm = imm_u;
			end
			OPC_AUIPC: begin
				instr_class = ALU;
				imm = imm_u;
				a_sel_pc = 1'b1;
			end
			OPC_JAL: begin
				instr_class = JAL;
				imm = imm_j;
				a_sel_pc = 1'b1;     // Target is PC plus offset.
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					instr_class = JALR;
				end
			end
			OPC_BRANCH: begin
				instr_class = BRANCH;
				imm = imm_b;
				a_sel_pc = 1'b1;
				case (funct3)
					3'b000:  branch_cond = EQ;
					3'b001:  branch_cond = NE;
					3'b100:  branch_cond = LT;
					3'b101:  branch_cond = GE;
					3'b110:  branch_cond = LTU;
					3'b111:  branch_cond = GEU;
					default: instr_class = HALT;
				endcase
			end
			OPC_LOAD: begin
				instr_class = LOAD;
				mem_signed = !funct3[2];   // LBU and LHU zero-extend.
				case (funct3)
					3'b000, 3'b100: mem_size = BYTE;
					3'b001, 3'b101: mem_size = HALF;
					3'b010:         mem_size = WORD;
					default:        instr_class = HALT;
				endcase
			end
			OPC_STORE: begin
				instr_class = STORE;
				imm = imm_s;
				case (funct3)
					3'b000:  mem_size = BYTE;
					3'b001:  mem_size = HALF;
					3'b010:  mem_size = WORD;
					default: instr_class = HALT;
				endcase
			end
			OPC_OP_IMM: begin
				alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3[1:0] != 2'b01 || funct7_ok) begin
					instr_class = ALU;   // Shifts need a legal funct7.
				end
			end
			OPC_OP: begin
				alu_op = arith_op(funct3, funct7[5]);
				b_sel_imm = 1'b0;
				if (funct7_ok) begin
					instr_class = ALU;
				end
			end
			default: instr_class = HALT;
		endcase
	end

endmodule

`default_nettype wire

// File: src/frisc_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_regfile import frisc_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [reg_addr_width-1:0] rs1,
	input  logic [reg_addr_width-1:0] rs2,
	input  logic [reg_addr_width-1:0] rd,
	input  logic [xlen-1:0]           rd_wdata,
	input  logic                      rd_wen,
	output logic [xlen-1:0]           rs1_data,
	output logic [xlen-1:0]           rs2_data
);

	logic [xlen-1:0] regs [1:31];  // x0 has no storage.

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && rd != '0) begin
			regs[rd] <= rd_wdata;
		end
	end

	// Combinational reads, x0 reads as zero.
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: src/frisc_alu.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_alu import frisc_pkg::*; (
	input  alu_op_t         alu_op,
	input  branch_cond_t    branch_cond,
	input  logic [xlen-1:0] operand_a,
	input  logic [xlen-1:0] operand_b,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	output logic [xlen-1:0] alu_result,
	output logic            branch_taken
);

	logic [4:0] shamt;
	logic       rs_eq;
	logic       rs_lt;
	logic       rs_ltu;

	assign shamt = operand_b[4:0];

	// ----------------------------------------
	// Arithmetic and logic
	// ----------------------------------------
	always_comb begin
		case (alu_op)
			ADD:     alu_result = operand_a + operand_b;
			SUB:     alu_result = operand_a - operand_b;
			SLL:     alu_result = operand_a << shamt;
			SLT:     alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			SLTU:    alu_result = {31'b0, operand_a < operand_b};
			XOR:     alu_result = operand_a ^ operand_b;
			SRL:     alu_result = operand_a >> shamt;
			SRA:     alu_result = $unsigned($signed(operand_a) >>> shamt);
			OR:      alu_result = operand_a | operand_b;
			AND:     alu_result = operand_a & operand_b;
			PASS_B:  alu_result = operand_b;
			default: alu_result = '0;
		endcase
	end

	// ----------------------------------------
	// Branch compare on the register operands
	// ----------------------------------------
	assign rs_eq = (rs1_data == rs2_data);
	assign rs_lt = ($signed(rs1_data) < $signed(rs2_data));
	assign rs_ltu = (rs1_data < rs2_data);

	always_comb begin
		case (branch_cond)
			EQ:      branch_taken = rs_eq;
			NE:      branch_taken = !rs_eq;
			LT:      branch_taken = rs_lt;
			GE:      branch_taken = !rs_lt;
			LTU:     branch_taken = rs_ltu;
			GEU:     branch_taken = !rs_ltu;
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/frisc_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_lsu import frisc_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            mem_req,
	input  instr_class_t    instr_class,
	input  mem_size_t       mem_size,
	input  logic            mem_signed,
	input  logic [xlen-1:0] address,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] drdata,
	input  logic            dready,
	output logic [xlen-1:0] daddr,
	output logic [xlen-1:0] dwdata,
	output logic [3:0]      dwstb,
	output logic            dwrite,
	output logic            dvalid,
	output logic            mem_done,
	output logic [xlen-1:0] load_data
);

	logic [xlen-1:0] store_data;
	logic [3:0]      lane_mask;
	logic [xlen-1:0] read_word;
	logic [xlen-1:0] read_shifted;

	// Replicate store data and pick the byte lanes.
	always_comb begin
		case (mem_size)
			BYTE: begin
				store_data = {4{rs2_data[7:0]}};
				lane_mask = 4'b0001 << address[1:0];
			end
			HALF: begin
				store_data = {2{rs2_data[15:0]}};
				lane_mask = address[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				store_data = rs2_data;
				lane_mask = 4'b1111;
			end
		endcase
	end

	assign mem_done = dvalid & dready;

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end else if (mem_done) begin
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end else if (mem_req && !dvalid) begin
			dvalid <= 1'b1;
			dwrite <= (instr_class == STORE);
		end
	end

	// Request payload is frozen while dvalid is high.
	always_ff @(posedge clock) begin
		if (mem_req && !dvalid) begin
			daddr <= address;
			dwdata <= store_data;
			dwstb <= lane_mask;
		end
		if (mem_done && !dwrite) begin
			read_word <= drdata;   // Captured on the handshake cycle.
		end
	end

	// ----------------------------------------
	// Load alignment and extension
	// ----------------------------------------
	assign read_shifted = read_word >> {daddr[1:0], 3'b000};

	always_comb begin
		case (mem_size)
			BYTE:    load_data = {{24{mem_signed & read_shifted[7]}}, read_shifted[7:0]};
			HALF:    load_data = {{16{mem_signed & read_shifted[15]}}, read_shifted[15:0]};
			default: load_data = read_word;
		endcase
	end

endmodule

`default_nettype wire

// File: src/frisc_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_sequencer import frisc_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  instr_class_t instr_class,
	input  logic         fetch_done,
	input  logic         mem_done,
	output logic         fetch_req,
	output logic         pc_load,
	output logic         mem_req,
	output logic         rd_wen,
	output logic         halted
);

	seq_state_t state;
	seq_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				if (fetch_done) begin
					state_next = DECODE;
				end
			end
			DECODE: begin
				if (instr_class == HALT) begin
					state_next = HALTED;   // ECALL, EBREAK and illegal words.
				end else begin
					state_next = EXECUTE;
				end
			end
			EXECUTE: begin
				if (instr_class == LOAD || instr_class == STORE) begin
					state_next = MEMORY;
				end else begin
					state_next = WRITEBACK;
				end
			end
			MEMORY: begin
				if (mem_done) begin
					state_next = WRITEBACK;
				end
			end
			WRITEBACK: state_next = FETCH;
			HALTED:    state_next = HALTED;  // Left only by reset.
			default:   state_next = HALTED;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	assign fetch_req = (state == FETCH);
	assign mem_req = (state == MEMORY);
	assign pc_load = (state == WRITEBACK);
	assign halted = (state == HALTED);

	// Stores and branches leave rd alone.
	assign rd_wen = (state == WRITEBACK) &&
		(instr_class inside {ALU, LOAD, JAL, JALR});

endmodule

`default_nettype wire

// File: src/frisc_core.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_core import frisc_pkg::*; #(
	parameter logic [xlen-1:0] RESET_PC = '0
) (
	input  logic            clock,
	input  logic            reset,
	output logic [xlen-1:0] iaddr,
	input  logic [xlen-1:0] idata,
	output logic            ivalid,
	input  logic            iready,
	output logic [xlen-1:0] daddr,
	output logic [xlen-1:0] dwdata,
	output logic [3:0]      dwstb,
	output logic            dwrite,
	input  logic [xlen-1:0] drdata,
	output logic            dvalid,
	input  logic            dready,
	output logic            halted
);

	// ----------------------------------------
	// Internal nets
	// ----------------------------------------
	logic                      fetch_req;
	logic                      fetch_done;
	logic                      pc_load;
	logic                      mem_req;
	logic                      mem_done;
	logic                      rd_wen;
	logic [xlen-1:0]           pc;
	logic [xlen-1:0]           instr;
	instr_class_t              instr_class;
	alu_op_t                   alu_op;
	branch_cond_t              branch_cond;
	mem_size_t                 mem_size;
	logic                      mem_signed;
	logic [reg_addr_width-1:0] rs1;
	logic [reg_addr_width-1:0] rs2;
	logic [reg_addr_width-1:0] rd;
	logic [xlen-1:0]           imm;
	logic                      a_sel_pc;
	logic                      b_sel_imm;
	logic [xlen-1:0]           rs1_data;
	logic [xlen-1:0]           rs2_data;
	logic [xlen-1:0]           operand_a;
	logic [xlen-1:0]           operand_b;
	logic [xlen-1:0]           alu_result;
	logic                      branch_taken;
	logic [xlen-1:0]           load_data;
	logic [xlen-1:0]           rd_wdata;

	assign operand_a = a_sel_pc ? pc : rs1_data;
	assign operand_b = b_sel_imm ? imm : rs2_data;

	// Write-back source.
	always_comb begin
		case (instr_class)
			LOAD:      rd_wdata = load_data;
			JAL, JALR: rd_wdata = pc + 32'd4;  // Link address.
			default:   rd_wdata = alu_result;
		endcase
	end

	frisc_sequencer u_sequencer (
		.clock       (clock      ),
		.reset       (reset      ),
		.instr_class (instr_class),
		.fetch_done  (fetch_done ),
		.mem_done    (mem_done   ),
		.fetch_req   (fetch_req  ),
		.pc_load     (pc_load    ),
		.mem_req     (mem_req    ),
		.rd_wen      (rd_wen     ),
		.halted      (halted     )
	);

	frisc_fetch #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clock        (clock       ),
		.reset        (reset       ),
		.fetch_req    (fetch_req   ),
		.pc_load      (pc_load     ),
		.iready       (iready      ),
		.idata        (idata       ),
		.instr_class  (instr_class ),
		.branch_taken (branch_taken),
		.alu_result   (alu_result  ),
		.iaddr        (iaddr       ),
		.ivalid       (ivalid      ),
		.fetch_done   (fetch_done  ),
		.pc           (pc          ),
		.instr        (instr       )
	);

	frisc_decode u_decode (
		.instr       (instr      ),
		.instr_class (instr_class),
		.alu_op      (alu_op     ),
		.branch_cond (branch_cond),
		.mem_size    (mem_size   ),
		.mem_signed  (mem_signed ),
		.rs1         (rs1        ),
		.rs2         (rs2        ),
		.rd          (rd         ),
		.imm         (imm        ),
		.a_sel_pc    (a_sel_pc   ),
		.b_sel_imm   (b_sel_imm  )
	);

	frisc_regfile u_regfile (
		.clock    (clock   ),
		.reset    (reset   ),
		.rs1      (rs1     ),
		.rs2      (rs2     ),
		.rd       (rd      ),
		.rd_wdata (rd_wdata),
		.rd_wen   (rd_wen  ),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	frisc_alu u_alu (
		.alu_op       (alu_op      ),
		.branch_cond  (branch_cond ),
		.operand_a    (operand_a   ),
		.operand_b    (operand_b   ),
		.rs1_data     (rs1_data    ),
		.rs2_data     (rs2_data    ),
		.alu_result   (alu_result  ),
		.branch_taken (branch_taken)
	);

	frisc_lsu u_lsu (
		.clock       (clock      ),
		.reset       (reset      ),
		.mem_req     (mem_req    ),
		.instr_class (instr_class),
		.mem_size    (mem_size   ),
		.mem_signed  (mem_signed ),
		.address     (alu_result ),
		.rs2_data    (rs2_data   ),
		.drdata      (drdata     ),
		.dready      (dready     ),
		.daddr       (daddr      ),
		.dwdata      (dwdata     ),
		.dwstb       (dwstb      ),
		.dwrite      (dwrite     ),
		.dvalid      (dvalid     ),
		.mem_done    (mem_done   ),
		.load_data   (load_data  )
	);

endmodule

`default_nettype wire

// File: dv/frisc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frisc_tb;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	logic        clock;
	logic        reset;
	logic [31:0] iaddr;
	logic [31:0] idata;
	logic        ivalid;
	logic        iready;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [3:0]  dwstb;
	logic        dwrite;
	logic [31:0] drdata;
	logic        dvalid;
	logic        dready;
	logic        halted;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] exp_addr [0:63];
	logic [31:0] exp_data [0:63];
	logic [3:0]  exp_strb [0:63];
	int          n_exp;
	int          exp_idx;
	int          cycle_count;
	int          cycle_limit;
	logic        running;

	// Previous-cycle state for the hold checks.
	logic        i_waiting;
	logic [31:0] i_addr_held;
	logic        d_waiting;
	logic [31:0] d_addr_held;
	logic [31:0] d_data_held;
	logic [3:0]  d_strb_held;
	logic        d_write_held;

	frisc_core #(
		.RESET_PC (RESET_PC)
	) frisc_core_inst (
		.clock  (clock ),
		.reset  (reset ),
		.iaddr  (iaddr ),
		.idata  (idata ),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr ),
		.dwdata (dwdata),
		.dwstb  (dwstb ),
		.dwrite (dwrite),
		.drdata (drdata),
		.dvalid (dvalid),
		.dready (dready),
		.halted (halted)
	);

	always #10 clock = ~clock;  // 20 ns period.

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic stop_with(input string reason);
		$display("Error at %0t ns: %s", $time, reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	function automatic logic [31:0] lane_bits(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	// ----------------------------------------
	// Data file loading
	// ----------------------------------------
	task automatic load_image();
		int          fd;
		int          code;
		string       line;
		byte         kind;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		fd = $fopen("dv/frisc_tb_input.txt", "r");
		if (fd == 0) begin
			stop_with("cannot open dv/frisc_tb_input.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			kind = line.getc(0);
			code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, s);
			if (kind == "P") begin
				imem[a[9:2]] = d;
			end else if (kind == "D") begin
				dmem[a[9:2]] = d;
			end else if (kind == "S") begin
				exp_addr[n_exp] = a;
				exp_data[n_exp] = d;
				exp_strb[n_exp] = s[3:0];
				n_exp++;
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// Memory models, driven on the falling edge
	// ----------------------------------------
	always @(negedge clock) begin
		if (running) begin
			if (i_waiting && (!ivalid || iaddr !== i_addr_held)) begin
				stop_with("instruction request changed before iready");
			end
			if (d_waiting && (!dvalid || daddr !== d_addr_held || dwdata !== d_data_held ||
					dwstb !== d_strb_held || dwrite !== d_write_held)) begin
				stop_with("data request changed before dready");
			end
			iready = ($urandom % 4) != 0;
			dready = ($urandom % 3) != 0;
			idata = imem[iaddr[9:2]];
			drdata = dmem[daddr[9:2]];
			// Transfer completes at the next rising edge.
			if (dvalid && dready && dwrite) begin
				if (exp_idx >= n_exp) begin
					stop_with("store seen after the last expected store");
				end
				// Byte offset within the word is carried by the strobe.
				compare("store address", {daddr[31:2], 2'b00}, exp_addr[exp_idx]);
				compare("store data", dwdata & lane_bits(dwstb), exp_data[exp_idx]);
				compare("store strobe", {28'b0, dwstb}, {28'b0, exp_strb[exp_idx]});
				dmem[daddr[9:2]] = (dmem[daddr[9:2]] & ~lane_bits(dwstb)) |
					(dwdata & lane_bits(dwstb));
				exp_idx++;
			end
			i_waiting = ivalid && !iready;
			i_addr_held = iaddr;
			d_waiting = dvalid && !dready;
			d_addr_held = daddr;
			d_data_held = dwdata;
			d_strb_held = dwstb;
			d_write_held = dwrite;
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				stop_with("timeout before the core halted");
			end
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		idata = '0;
		iready = 1'b0;
		drdata = '0;
		dready = 1'b0;
		running = 1'b0;
		i_waiting = 1'b0;
		d_waiting = 1'b0;
		n_exp = 0;
		exp_idx = 0;
		cycle_count = 0;
		cycle_limit = 1000000;
		void'($urandom(32'h3a4d));
		for (int i = 0; i < 256; i++) begin
			imem[i] = i << 7;  // Opcode zero decodes as illegal.
			dmem[i] = (i * 4) ^ 32'hC3A5_0000;
		end
		load_image();
		cycle_limit = 200 * n_exp + 2000;

		repeat (8) @(negedge clock);
		reset = 1'b0;
		compare("ivalid after reset", {31'b0, ivalid}, 32'd0);
		compare("dvalid after reset", {31'b0, dvalid}, 32'd0);
		compare("dwrite after reset", {31'b0, dwrite}, 32'd0);
		compare("halted after reset", {31'b0, halted}, 32'd0);
		@(posedge clock);
		running = 1'b1;

		// First request one cycle after reset falls.
		@(negedge clock);
		compare("ivalid one cycle after reset", {31'b0, ivalid}, 32'd1);
		compare("first fetch address", iaddr, RESET_PC);

		while (!halted) begin
			@(negedge clock);
		end
		if (exp_idx != n_exp) begin
			stop_with("core halted before all expected stores");
		end else begin
			// Halted core must stay quiet.
			repeat (20) begin
				@(negedge clock);
				if (ivalid || dvalid) begin
					stop_with("request seen after halt");
				end
			end
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
src/frisc_pkg.sv
src/frisc_fetch.sv
src/frisc_decode.sv
src/frisc_regfile.sv
src/frisc_alu.sv
src/frisc_lsu.sv
src/frisc_sequencer.sv
src/frisc_core.sv
dv/frisc_tb.sv

// File: Makefile
# Verilator build and run for the frisc core testbench.

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove build output and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module frisc_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vfrisc_tb | tee sim.log
	@grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// File: dv/frisc_tb_input.txt
# P <addr> <instr> : program word; D <addr> <word> : initial data word
# S <addr> <data masked by strobe> <strobe> : expected store, in order
P 00000000 123450B7
P 00000004 67808093
P 00000008 20000113
P 0000000C 00112023
P 00000010 00001197
P 00000014 00312223
P 00000018 FFB00213
P 0000001C 404082B3
P 00000020 40125313
P 00000024 000223B3
P 00000028 0062C433
P 0000002C 00740433
P 00000030 00812423
P 00000034 00620463
P 00000038 01100493
P 0000003C 00912623
P 00000040 00624663
P 00000044 BAD00493
P 00000048 00912823
P 0000004C 00C0056F
P 00000050 00012823
P 00000054 00000073
P 00000058 00A12823
P 0000005C 06C00593
P 00000060 00158667
P 00000064 00000073
P 00000068 00000073
P 0000006C 00C12A23
P 00000070 001100A3
P 00000074 00411323
P 00000078 00710683
P 0000007C 00714703
P 00000080 00611783
P 00000084 00615803
P 00000088 00012883
P 0000008C 00D12C23
P 00000090 00E12E23
P 00000094 02F12023
P 00000098 03012223
P 0000009C 03112423
P 000000A0 03012903
P 000000A4 00491913
P 000000A8 03212623
P 000000AC 00000073
D 00000230 0BADF00D
S 00000200 12345678 F
S 00000204 00001010 F
S 00000208 EDCBA981 F
S 0000020C 00000011 F
S 00000210 00000050 F
S 00000214 00000064 F
S 00000200 00007800 2
S 00000204 FFFB0000 C
S 00000218 FFFFFFFF F
S 0000021C 000000FF F
S 00000220 FFFFFFFB F
S 00000224 0000FFFB F
S 00000228 12347878 F
S 0000022C BADF00D0 F
